// File: all.f
source/frogger_pkg.sv
source/ps2_receiver.sv
source/frog_game.sv
source/vga_scan.sv
source/field_renderer.sv
source/frogger_top.sv
tests/frogger_checker.sv
tests/frogger_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS ?= --binary --timing --assert
TOP ?= frogger_tb
FILELIST ?= all.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "STATUS: FAIL" $(LOG) || ! grep -q "STATUS: PASS" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: tests/frogger_tb.sv
`timescale 1ns/1ns
`default_nettype none

module frogger_tb;

	localparam int TILE_PX = 4;
	localparam int PORCH = 2;
	localparam int CAR_PERIOD = 97;
	localparam int H_VIS = frogger_pkg::GRID_COLS * TILE_PX;
	localparam int V_VIS = frogger_pkg::GRID_ROWS * TILE_PX;
	localparam int H_TOTAL = H_VIS + 3 * PORCH;
	localparam int V_TOTAL = V_VIS + 3 * PORCH;
	localparam int NUM_KEYS = 300;
	// 300 keys of at most 86 cycles, ten opening keys, two video frames at the end, margin
	localparam int TIMEOUT_CYCLES = 30000;

	logic clk;
	logic rst;
	logic ps2_clk;
	logic ps2_data;
	logic vga_red;
	logic vga_green;
	logic vga_blue;
	logic vga_hsync;
	logic vga_vsync;
	frogger_pkg::status_t status;

	int seed;
	int cyc;
	int error_count;
	int k;
	int sel;
	logic [7:0] next_code;
	frogger_pkg::status_t exp_status;
	frogger_pkg::rgb_t exp_rgb;
	logic [1:0] exp_sync;
	logic [7:0] pend_code[$];
	int pend_cyc[$];
	logic break_pending;

	frogger_top #(
		.TILE_PX(TILE_PX),
		.H_FRONT(PORCH),
		.H_SYNC(PORCH),
		.H_BACK(PORCH),
		.V_FRONT(PORCH),
		.V_SYNC(PORCH),
		.V_BACK(PORCH),
		.CAR_PERIOD(CAR_PERIOD)
	) frogger_top_inst (
		.clk(clk),
		.rst(rst),
		.ps2_clk(ps2_clk),
		.ps2_data(ps2_data),
		.vga_red(vga_red),
		.vga_green(vga_green),
		.vga_blue(vga_blue),
		.vga_hsync(vga_hsync),
		.vga_vsync(vga_vsync),
		.status(status)
	);

	bind frog_game frogger_checker frogger_checker_inst (
		.clk(clk),
		.rst(rst),
		.key(key),
		.status(status)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	//////////////////////////////////////////////////
	// Reference model
	//////////////////////////////////////////////////

	// Output after edge n shows the scan position and field of edge n-1
	task automatic predict_video(input int n);
		int h;
		int v;
		frogger_pkg::tile_col_t col;
		frogger_pkg::tile_row_t row;
		h = n % H_TOTAL;
		v = (n / H_TOTAL) % V_TOTAL;
		col = frogger_pkg::tile_col_t'(h / TILE_PX);
		row = frogger_pkg::tile_row_t'(v / TILE_PX);
		exp_sync = {!(h >= H_VIS + PORCH && h < H_VIS + 2 * PORCH),
			!(v >= V_VIS + PORCH && v < V_VIS + 2 * PORCH)};
		if (h >= H_VIS || v >= V_VIS)
			exp_rgb = frogger_pkg::COLOR_BLANK;
		else if (col == exp_status.field.frog_col && row == exp_status.field.frog_row)
			exp_rgb = frogger_pkg::COLOR_FROG;
		else if (row == frogger_pkg::CAR_ROW && col == exp_status.field.car_col)
			exp_rgb = frogger_pkg::COLOR_CAR;
		else if (row == frogger_pkg::CAR_ROW)
			exp_rgb = frogger_pkg::COLOR_ROAD;
		else if (row == frogger_pkg::HOME_ROW)
			exp_rgb = frogger_pkg::COLOR_HOME;
		else
			exp_rgb = frogger_pkg::COLOR_GRASS;
	endtask

	task automatic step_game(input int n);
		logic have_key;
		logic [7:0] code;
		int col;
		int row;
		have_key = 1'b0;
		code = 8'h00;
		if (pend_cyc.size() > 0 && pend_cyc[0] == n) begin
			have_key = 1'b1;
			code = pend_code.pop_front();
			void'(pend_cyc.pop_front());
		end
		col = int'(exp_status.field.frog_col);
		row = int'(exp_status.field.frog_row);
		if (exp_status.state == frogger_pkg::GAME_PLAY) begin
			// Collision wins over a key in the same cycle
			if (row == int'(frogger_pkg::CAR_ROW) &&
				exp_status.field.frog_col == exp_status.field.car_col) begin
				exp_status.state = frogger_pkg::GAME_OVER;
			end else if (have_key) begin
				case (code)
					frogger_pkg::KEY_UP: row = (row > 0) ? row - 1 : row;
					frogger_pkg::KEY_DOWN: row = (row < frogger_pkg::GRID_ROWS - 1) ? row + 1 : row;
					frogger_pkg::KEY_LEFT: col = (col > 0) ? col - 1 : col;
					frogger_pkg::KEY_RIGHT: col = (col < frogger_pkg::GRID_COLS - 1) ? col + 1 : col;
					default: ;
				endcase
				if (row == int'(frogger_pkg::HOME_ROW)) begin
					exp_status.score = exp_status.score + 4'd1;
					col = int'(frogger_pkg::START_COL);
					row = int'(frogger_pkg::START_ROW);
				end
			end
		end else if (have_key && code == frogger_pkg::KEY_START) begin
			exp_status.state = frogger_pkg::GAME_PLAY;
			exp_status.score = 4'd0;
			col = int'(frogger_pkg::START_COL);
			row = int'(frogger_pkg::START_ROW);
		end
		exp_status.field.frog_col = frogger_pkg::tile_col_t'(col);
		exp_status.field.frog_row = frogger_pkg::tile_row_t'(row);
	endtask

	always @(posedge clk) begin
		if (rst) begin
			cyc = 0;
			exp_status.state = frogger_pkg::GAME_IDLE;
			exp_status.score = 4'd0;
			exp_status.field.frog_col = frogger_pkg::START_COL;
			exp_status.field.frog_row = frogger_pkg::START_ROW;
			exp_status.field.car_col = 3'd0;
			exp_rgb = frogger_pkg::COLOR_BLANK;
			exp_sync = 2'b11;
		end else begin
			cyc = cyc + 1;
			predict_video(cyc - 1);
			step_game(cyc);
			exp_status.field.car_col =
				frogger_pkg::tile_col_t'((cyc / CAR_PERIOD) % frogger_pkg::GRID_COLS);
		end
	end

	//////////////////////////////////////////////////
	// Compare tasks
	//////////////////////////////////////////////////

	task automatic check_status(input frogger_pkg::status_t got,
		input frogger_pkg::status_t exp, input string what);
		if (got !== exp) begin
			error_count++;
			$display("CHECK FAILED at %0t ns: %s got %h expected %h", $time, what, got, exp);
			$display("STATUS: FAIL");
			$fatal(1, "status mismatch");
		end
	endtask

	task automatic check_rgb(input frogger_pkg::rgb_t got,
		input frogger_pkg::rgb_t exp, input string what);
		if (got !== exp) begin
			error_count++;
			$display("CHECK FAILED at %0t ns: %s got %b expected %b", $time, what, got, exp);
			$display("STATUS: FAIL");
			$fatal(1, "colour mismatch");
		end
	endtask

	task automatic check_sync(input logic [1:0] got, input logic [1:0] exp, input string what);
		if (got !== exp) begin
			error_count++;
			$display("CHECK FAILED at %0t ns: %s got %b expected %b", $time, what, got, exp);
			$display("STATUS: FAIL");
			$fatal(1, "sync mismatch");
		end
	endtask

	always @(negedge clk) begin
		if (!rst) begin
			check_status(status, exp_status, "game status");
			check_rgb(frogger_pkg::rgb_t'({vga_red, vga_green, vga_blue}), exp_rgb, "pixel colour");
			check_sync({vga_hsync, vga_vsync}, exp_sync, "hsync and vsync");
			if (cyc >= TIMEOUT_CYCLES) begin
				$display("Timeout: run still going after %0d cycles", cyc);
				$display("STATUS: FAIL");
				$fatal(1, "timeout");
			end
		end
	end

	//////////////////////////////////////////////////
	// Stimulus
	//////////////////////////////////////////////////

	function automatic int rand_below(input int n);
		int r;
		r = $random(seed);
		return (r & 32'h7fff_ffff) % n;
	endfunction

	// Each step lands 5 ns after a rising edge
	task automatic wait_cycles(input int n);
		repeat (n) @(posedge clk);
		#5;
	endtask

	// Half period of 3 clocks, data changes while the PS/2 clock is high
	task automatic send_frame(input logic [7:0] code, input logic bad_parity);
		logic [10:0] bits;
		int low_cyc;
		bits = {1'b1, ~(^code) ^ bad_parity, code, 1'b0};
		low_cyc = 0;
		for (int i = 0; i < 11; i++) begin
			ps2_data = bits[i];
			ps2_clk = 1'b1;
			wait_cycles(3);
			ps2_clk = 1'b0;
			low_cyc = cyc;
			wait_cycles(3);
		end
		ps2_clk = 1'b1;
		ps2_data = 1'b1;
		// Strobe 4 edges after the last low is driven, status one edge later
		if (!bad_parity) begin
			if (break_pending)
				break_pending = 1'b0;
			else if (code == frogger_pkg::KEY_BREAK)
				break_pending = 1'b1;
			else begin
				pend_code.push_back(code);
				pend_cyc.push_back(low_cyc + 5);
			end
		end
	endtask

	initial begin
		seed = 32'h0e87b0f6;
		error_count = 0;
		break_pending = 1'b0;
		rst = 1'b1;
		ps2_clk = 1'b1;
		ps2_data = 1'b1;
		repeat (4) @(posedge clk);
		#5;
		rst = 1'b0;
		// Arrow while idle, then walk the frog into the left edge
		send_frame(frogger_pkg::KEY_LEFT, 1'b0);
		wait_cycles(4);
		send_frame(frogger_pkg::KEY_START, 1'b0);
		wait_cycles(4);
		for (k = 0; k < frogger_pkg::GRID_COLS; k++) begin
			send_frame(frogger_pkg::KEY_LEFT, 1'b0);
			wait_cycles(4);
		end
		for (k = 0; k < NUM_KEYS; k++) begin
			sel = rand_below(16);
			if (sel < 6)
				next_code = frogger_pkg::KEY_UP;
			else if (sel < 8)
				next_code = frogger_pkg::KEY_DOWN;
			else if (sel < 10)
				next_code = frogger_pkg::KEY_LEFT;
			else if (sel < 12)
				next_code = frogger_pkg::KEY_RIGHT;
			else if (sel < 14)
				next_code = frogger_pkg::KEY_START;
			else
				next_code = frogger_pkg::KEY_BREAK;
			send_frame(next_code, rand_below(8) == 0);
			wait_cycles(4 + rand_below(16));
		end
		wait_cycles(2 * H_TOTAL * V_TOTAL);
		if (error_count == 0) begin
			$display("STATUS: PASS");
			$finish;
		end else begin
			$display("STATUS: FAIL");
			$fatal(1, "checks failed");
		end
	end

endmodule

`default_nettype wire

// File: tests/frogger_checker.sv
`timescale 1ns/1ns
`default_nettype none

module frogger_checker (
	input logic clk,
	input logic rst,
	input frogger_pkg::key_event_t key,
	input frogger_pkg::status_t status
);

	frog_on_grid: assert property (@(posedge clk) disable iff (rst)
		int'(status.field.frog_row) < frogger_pkg::GRID_ROWS)
		else $error("frog outside the grid");

	// Only a start key gets out of over
	over_holds: assert property (@(posedge clk) disable iff (rst)
		(status.state == frogger_pkg::GAME_OVER &&
		!(key.valid && key.code == frogger_pkg::KEY_START))
		|=> status.state == frogger_pkg::GAME_OVER)
		else $error("game left over without a start key");

	single_strobe: assert property (@(posedge clk) disable iff (rst)
		key.valid |=> !key.valid)
		else $error("key valid high for two cycles");

endmodule

`default_nettype wire

// File: source/frogger_top.sv
`timescale 1ns/1ns
`default_nettype none

module frogger_top #(
	parameter int TILE_PX = 100,
	parameter int H_FRONT = 56,
	parameter int H_SYNC = 120,
	parameter int H_BACK = 64,
	parameter int V_FRONT = 37,
	parameter int V_SYNC = 6,
	parameter int V_BACK = 23,
	parameter int CAR_PERIOD = 20_000_000
) (
	input logic clk,
	input logic rst,
	input logic ps2_clk,
	input logic ps2_data,
	output logic vga_red,
	output logic vga_green,
	output logic vga_blue,
	output logic vga_hsync,
	output logic vga_vsync,
	output frogger_pkg::status_t status
);

	frogger_pkg::key_event_t key;
	frogger_pkg::scan_t scan;

	ps2_receiver ps2_receiver_inst (
		.clk(clk),
		.rst(rst),
		.ps2_clk(ps2_clk),
		.ps2_data(ps2_data),
		.key(key)
	);

	frog_game #(
		.CAR_PERIOD(CAR_PERIOD)
	) frog_game_inst (
		.clk(clk),
		.rst(rst),
		.key(key),
		.status(status)
	);

	vga_scan #(
		.TILE_PX(TILE_PX),
		.H_FRONT(H_FRONT),
		.H_SYNC(H_SYNC),
		.H_BACK(H_BACK),
		.V_FRONT(V_FRONT),
		.V_SYNC(V_SYNC),
		.V_BACK(V_BACK)
	) vga_scan_inst (
		.clk(clk),
		.rst(rst),
		.scan(scan)
	);

	field_renderer field_renderer_inst (
		.clk(clk),
		.rst(rst),
		.scan(scan),
		.field(status.field),
		.vga_red(vga_red),
		.vga_green(vga_green),
		.vga_blue(vga_blue),
		.vga_hsync(vga_hsync),
		.vga_vsync(vga_vsync)
	);

endmodule

`default_nettype wire

// File: source/field_renderer.sv
`timescale 1ns/1ns
`default_nettype none

module field_renderer (
	input logic clk,
	input logic rst,
	input frogger_pkg::scan_t scan,
	input frogger_pkg::field_t field,
	output logic vga_red,
	output logic vga_green,
	output logic vga_blue,
	output logic vga_hsync,
	output logic vga_vsync
);

	frogger_pkg::rgb_t pix;
	frogger_pkg::rgb_t color;
	logic hsync_q;
	logic vsync_q;

	// Tile priority, frog drawn over the car
	always_comb begin
		if (!scan.visible)
			pix = frogger_pkg::COLOR_BLANK;
		else if (scan.col == field.frog_col && scan.row == field.frog_row)
			pix = frogger_pkg::COLOR_FROG;
		else if (scan.row == frogger_pkg::CAR_ROW && scan.col == field.car_col)
			pix = frogger_pkg::COLOR_CAR;
		else if (scan.row == frogger_pkg::CAR_ROW)
			pix = frogger_pkg::COLOR_ROAD;
		else if (scan.row == frogger_pkg::HOME_ROW)
			pix = frogger_pkg::COLOR_HOME;
		else
			pix = frogger_pkg::COLOR_GRASS;
	end

	// Colour and syncs share one register stage
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			color <= frogger_pkg::COLOR_BLANK;
			hsync_q <= 1'b1;
			vsync_q <= 1'b1;
		end else begin
			color <= pix;
			hsync_q <= scan.hsync;
			vsync_q <= scan.vsync;
		end
	end

	assign vga_red = color.red;
	assign vga_green = color.green;
	assign vga_blue = color.blue;
	assign vga_hsync = hsync_q;
	assign vga_vsync = vsync_q;

endmodule

`default_nettype wire

// File: source/vga_scan.sv
`timescale 1ns/1ns
`default_nettype none

module vga_scan #(
	parameter int TILE_PX = 100,
	parameter int H_FRONT = 56,
	parameter int H_SYNC = 120,
	parameter int H_BACK = 64,
	parameter int V_FRONT = 37,
	parameter int V_SYNC = 6,
	parameter int V_BACK = 23
) (
	input logic clk,
	input logic rst,
	output frogger_pkg::scan_t scan
);

	localparam int H_VIS = frogger_pkg::GRID_COLS * TILE_PX;
	localparam int V_VIS = frogger_pkg::GRID_ROWS * TILE_PX;
	localparam int H_TOTAL = H_VIS + H_FRONT + H_SYNC + H_BACK;
	localparam int V_TOTAL = V_VIS + V_FRONT + V_SYNC + V_BACK;
	localparam int H_W = $clog2(H_TOTAL + 1);
	localparam int V_W = $clog2(V_TOTAL + 1);
	localparam int S_W = $clog2(TILE_PX + 1);

	logic [H_W-1:0] h_cnt;
	logic [V_W-1:0] v_cnt;
	logic [S_W-1:0] h_sub;
	logic [S_W-1:0] v_sub;
	frogger_pkg::tile_col_t h_tile;
	frogger_pkg::tile_row_t v_tile;
	logic line_end;
	logic frame_end;

	assign line_end = (h_cnt == H_W'(H_TOTAL - 1));
	assign frame_end = (v_cnt == V_W'(V_TOTAL - 1));

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			h_cnt <= '0;
			h_sub <= '0;
			h_tile <= '0;
		end else if (line_end) begin
			h_cnt <= '0;
			h_sub <= '0;
			h_tile <= '0;
		end else begin
			h_cnt <= h_cnt + 1'b1;
			if (h_sub == S_W'(TILE_PX - 1)) begin
				h_sub <= '0;
				h_tile <= h_tile + 3'd1;
			end else begin
				h_sub <= h_sub + 1'b1;
			end
		end
	end

	// Rows step once per line
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			v_cnt <= '0;
			v_sub <= '0;
			v_tile <= '0;
		end else if (line_end) begin
			if (frame_end) begin
				v_cnt <= '0;
				v_sub <= '0;
				v_tile <= '0;
			end else begin
				v_cnt <= v_cnt + 1'b1;
				if (v_sub == S_W'(TILE_PX - 1)) begin
					v_sub <= '0;
					v_tile <= v_tile + 3'd1;
				end else begin
					v_sub <= v_sub + 1'b1;
				end
			end
		end
	end

	assign scan = frogger_pkg::scan_t'{
		visible: (h_cnt < H_W'(H_VIS)) && (v_cnt < V_W'(V_VIS)),
		hsync: !((h_cnt >= H_W'(H_VIS + H_FRONT)) && (h_cnt < H_W'(H_VIS + H_FRONT + H_SYNC))),
		vsync: !((v_cnt >= V_W'(V_VIS + V_FRONT)) && (v_cnt < V_W'(V_VIS + V_FRONT + V_SYNC))),
		col: h_tile,
		row: v_tile
	};

endmodule

`default_nettype wire

// File: source/frog_game.sv
`timescale 1ns/1ns
`default_nettype none

module frog_game #(
	parameter int CAR_PERIOD = 20_000_000
) (
	input logic clk,
	input logic rst,
	input frogger_pkg::key_event_t key,
	output frogger_pkg::status_t status
);

	localparam int CNT_W = $clog2(CAR_PERIOD + 1);

	frogger_pkg::game_state_e state;
	logic [3:0] score;
	frogger_pkg::tile_col_t frog_col;
	frogger_pkg::tile_row_t frog_row;
	frogger_pkg::tile_col_t car_col;
	logic [CNT_W-1:0] car_cnt;
	frogger_pkg::tile_col_t next_col;
	frogger_pkg::tile_row_t next_row;
	logic hit;
	logic start_key;

	//////////////////////////////////////////////////
	// Car lane
	//////////////////////////////////////////////////

	// Runs in every state, the 3-bit column wraps 7 to 0
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			car_cnt <= '0;
			car_col <= '0;
		end else if (car_cnt == CNT_W'(CAR_PERIOD - 1)) begin
			car_cnt <= '0;
			car_col <= car_col + 3'd1;
		end else begin
			car_cnt <= car_cnt + 1'b1;
		end
	end

	//////////////////////////////////////////////////
	// Frog movement and game FSM
	//////////////////////////////////////////////////

	// Clamped one-tile step
	always_comb begin
		next_col = frog_col;
		next_row = frog_row;
		case (key.code)
			frogger_pkg::KEY_UP:
				if (frog_row != '0)
					next_row = frog_row - 3'd1;
			frogger_pkg::KEY_DOWN:
				if (frog_row != frogger_pkg::tile_row_t'(frogger_pkg::GRID_ROWS - 1))
					next_row = frog_row + 3'd1;
			frogger_pkg::KEY_LEFT:
				if (frog_col != '0)
					next_col = frog_col - 3'd1;
			frogger_pkg::KEY_RIGHT:
				if (frog_col != frogger_pkg::tile_col_t'(frogger_pkg::GRID_COLS - 1))
					next_col = frog_col + 3'd1;
			default: ;
		endcase
	end

	assign hit = (frog_row == frogger_pkg::CAR_ROW) && (frog_col == car_col);
	assign start_key = key.valid && (key.code == frogger_pkg::KEY_START);

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state <= frogger_pkg::GAME_IDLE;
			score <= '0;
			frog_col <= frogger_pkg::START_COL;
			frog_row <= frogger_pkg::START_ROW;
		end else begin
			case (state)
				frogger_pkg::GAME_PLAY: begin
					if (hit) begin
						state <= frogger_pkg::GAME_OVER;
					end else if (key.valid) begin
						if (next_row == frogger_pkg::HOME_ROW) begin
							score <= score + 4'd1;
							frog_col <= frogger_pkg::START_COL;
							frog_row <= frogger_pkg::START_ROW;
						end else begin
							frog_col <= next_col;
							frog_row <= next_row;
						end
					end
				end
				frogger_pkg::GAME_IDLE, frogger_pkg::GAME_OVER: begin
					if (start_key) begin
						state <= frogger_pkg::GAME_PLAY;
						score <= '0;
						frog_col <= frogger_pkg::START_COL;
						frog_row <= frogger_pkg::START_ROW;
					end
				end
				default: state <= frogger_pkg::GAME_IDLE;
			endcase
		end
	end

	assign status = frogger_pkg::status_t'{
		state: state,
		score: score,
		field: frogger_pkg::field_t'{frog_col: frog_col, frog_row: frog_row, car_col: car_col}
	};

endmodule

`default_nettype wire

// File: source/ps2_receiver.sv
`timescale 1ns/1ns
`default_nettype none

module ps2_receiver (
	input logic clk,
	input logic rst,
	input logic ps2_clk,
	input logic ps2_data,
	output frogger_pkg::key_event_t key
);

	logic [1:0] clk_sync;
	logic [1:0] data_sync;
	logic clk_prev;
	logic fall;
	logic [3:0] bit_cnt;
	logic [10:0] frame;
	logic frame_done;
	logic frame_ok;
	logic break_seen;
	logic key_valid;
	logic [7:0] key_code;

	// Both lines idle high
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			clk_sync <= 2'b11;
			data_sync <= 2'b11;
			clk_prev <= 1'b1;
		end else begin
			clk_sync <= {clk_sync[0], ps2_clk};
			data_sync <= {data_sync[0], ps2_data};
			clk_prev <= clk_sync[1];
		end
	end

	assign fall = clk_prev & ~clk_sync[1];

	// Start, 8 data bits LSB first, parity, stop
	always_ff @(posedge clk) begin
		if (fall)
			frame <= {data_sync[1], frame[10:1]};
	end

	assign frame_done = (bit_cnt == 4'd11);
	assign frame_ok = ~frame[0] & frame[10] & (^frame[9:1]);

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			bit_cnt <= '0;
			break_seen <= 1'b0;
			key_valid <= 1'b0;
		end else begin
			key_valid <= 1'b0;
			if (frame_done)
				bit_cnt <= '0;
			else if (fall)
				bit_cnt <= bit_cnt + 4'd1;
			if (frame_done && frame_ok) begin
				if (break_seen)
					break_seen <= 1'b0;
				else if (frame[8:1] == frogger_pkg::KEY_BREAK)
					break_seen <= 1'b1;
				else
					key_valid <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (frame_done)
			key_code <= frame[8:1];
	end

	assign key = frogger_pkg::key_event_t'{valid: key_valid, code: key_code};

endmodule

`default_nettype wire

// File: source/frogger_pkg.sv
`default_nettype none

package frogger_pkg;

	//////////////////////////////////////////////////
	// Playfield geometry
	//////////////////////////////////////////////////

	localparam int GRID_COLS = 8;
	localparam int GRID_ROWS = 6;

	typedef logic [2:0] tile_col_t;
	typedef logic [2:0] tile_row_t;

	localparam tile_row_t HOME_ROW = 3'd0;
	localparam tile_row_t CAR_ROW = 3'd3;
	localparam tile_row_t START_ROW = 3'd5;
	localparam tile_col_t START_COL = 3'd7;

	typedef struct packed {
		logic red;
		logic green;
		logic blue;
	} rgb_t;

	localparam rgb_t COLOR_FROG = 3'b110;
	localparam rgb_t COLOR_CAR = 3'b100;
	localparam rgb_t COLOR_ROAD = 3'b000;
	localparam rgb_t COLOR_HOME = 3'b001;
	localparam rgb_t COLOR_GRASS = 3'b010;
	localparam rgb_t COLOR_BLANK = 3'b000;

	//////////////////////////////////////////////////
	// Keyboard and game types
	//////////////////////////////////////////////////

	// Set 2 make codes
	typedef enum logic [7:0] {
		KEY_UP = 8'h75,
		KEY_DOWN = 8'h72,
		KEY_LEFT = 8'h6b,
		KEY_RIGHT = 8'h74,
		KEY_START = 8'h14,
		KEY_BREAK = 8'hf0
	} key_code_e;

	typedef enum logic [1:0] {
		GAME_IDLE,
		GAME_PLAY,
		GAME_OVER
	} game_state_e;

	typedef struct packed {
		logic valid;
		logic [7:0] code;
	} key_event_t;

	typedef struct packed {
		tile_col_t frog_col;
		tile_row_t frog_row;
		tile_col_t car_col;
	} field_t;

	typedef struct packed {
		game_state_e state;
		logic [3:0] score;
		field_t field;
	} status_t;

	typedef struct packed {
		logic visible;
		logic hsync;
		logic vsync;
		tile_col_t col;
		tile_row_t row;
	} scan_t;

endpackage

`default_nettype wire
